// File: z80_datapath.f
logic/datapath_pkg.sv
logic/register_file.sv
logic/alu.sv
logic/accum_flags.sv
logic/bus_arbiter.sv
logic/z80_datapath.sv
tests/tb_clock.sv
tests/z80_datapath_asserts.sv
tests/z80_datapath_tb.sv

// File: tests/z80_datapath_tb.sv
`default_nettype none

module z80_datapath_tb
  import datapath_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int OPS        = 200;
  localparam int TESTS      = 6;
  // 6 tests x 200 ops plus reset is about 1210 cycles, limit leaves margin
  localparam int MAX_CYCLES = 2000;

  logic   clk;
  logic   rst_n;
  ctl_t   ctl;
  byte_t  data_in;
  byte_t  data_out;
  logic   data_oe;
  word_t  addr_out;
  logic   addr_oe;
  flags_t flags;

  int    checks;
  int    errors;
  int    test_errors;
  int    cycles;
  int    assert_fails;
  string test_name;

  // ----------------------------------------------------------
  // reference model state and per-cycle predictions
  // ----------------------------------------------------------
  byte_t  m_regs [1:14];
  byte_t  m_alt [1:6];
  byte_t  m_a;
  byte_t  m_a_alt;
  flags_t m_f;
  flags_t m_f_alt;
  byte_t  m_temp;
  word_t  m_mar;
  byte_t  e_reg8;
  word_t  e_pair;
  byte_t  e_alu8;
  flags_t e_alu8_f;
  word_t  e_alu16;
  flags_t e_alu16_f;
  byte_t  e_dbus;
  word_t  e_abus;

  tb_clock #(.period_ns(8), .reset_cycles(8)) u_tb_clock (.clk, .rst_n);

  z80_datapath u_z80_datapath (
    .clk, .rst_n, .ctl, .data_in, .data_out, .data_oe, .addr_out, .addr_oe, .flags
  );

  bind z80_datapath z80_datapath_asserts u_z80_datapath_asserts (
    .clk, .rst_n, .ctl, .data_oe, .addr_oe
  );

  // arithmetic reference, w selects 8 or 16 bit behavior
  function automatic void alu_model(input int w, input word_t a, input word_t b,
                                    input alu_op_e op, input flags_t f_in,
                                    output word_t res, output flags_t f_out);
    logic [16:0] full;
    word_t       mask;
    word_t       b_ext;
    mask  = (w == 8) ? 16'h00ff : 16'hffff;
    b_ext = {{8{b[7]}}, b[7:0]} & mask;
    f_out = f_in;
    case (op)
      OP_INC:    full = {1'b0, a} + 17'd1;
      OP_DEC:    full = {1'b0, a} - 17'd1;
      OP_ADD:    full = {1'b0, a} + {1'b0, b};
      OP_ADD_SE: full = {1'b0, a} + {1'b0, b_ext};
      OP_PASS_B: full = {1'b0, b};
      default:   full = {1'b0, a};
    endcase
    res = full[15:0] & mask;
    if (op inside {OP_INC, OP_DEC, OP_ADD, OP_ADD_SE}) begin
      f_out.z = (res == 16'h0000);
      f_out.s = res[w-1];
    end
    if (op inside {OP_ADD, OP_ADD_SE}) begin
      f_out.c = full[w];
    end
    if (op == OP_DEC) begin
      f_out.pv = (res != 16'h0000);
    end
  endfunction

  function automatic logic force_bit(input logic cur, input force_e fc);
    case (fc)
      FORCE_SET: return 1'b1;
      FORCE_CLR: return 1'b0;
      default:   return cur;
    endcase
  endfunction

  // combinational view of the datapath for control word c
  task automatic predict(input ctl_t c, input byte_t din);
    word_t r;
    e_reg8 = (c.rd8 != R8_NONE) ? m_regs[c.rd8] : 8'h00;
    e_pair = (c.pair != P_NONE) ? {m_regs[2*c.pair-1], m_regs[2*c.pair]} : 16'h0000;
    alu_model(8, {8'h00, m_a}, {8'h00, din}, c.alu_op, m_f, r, e_alu8_f);
    e_alu8 = r[7:0];
    alu_model(16, e_pair, {8'h00, m_temp}, c.alu_op, m_f, e_alu16, e_alu16_f);
    case (c.dsrc)
      D_REG:   e_dbus = e_reg8;
      D_A:     e_dbus = m_a;
      D_F:     e_dbus = m_f;
      D_TEMP:  e_dbus = m_temp;
      D_ALU:   e_dbus = e_alu8;
      default: e_dbus = din;
    endcase
    case (c.asrc)
      A_PAIR:  e_abus = e_pair;
      A_MAR:   e_abus = m_mar;
      A_ALU:   e_abus = e_alu16;
      default: e_abus = 16'h0000;
    endcase
  endtask

  // register updates at the clock edge
  task automatic update_model(input ctl_t c);
    byte_t  old_main [1:6];
    flags_t f_new;
    byte_t  a_old;
    flags_t f_old;
    for (int i = 1; i <= 6; i++) begin
      old_main[i] = m_regs[i];
    end
    if (c.ld8 != R8_NONE) begin
      m_regs[c.ld8] = e_dbus;
    end else if (c.ld_pair && c.pair != P_NONE) begin
      m_regs[2*c.pair-1] = e_abus[15:8];
      m_regs[2*c.pair]   = e_abus[7:0];
    end
    // exx takes the pre-load main bank, so it wins over a load to B..L
    if (c.exx) begin
      for (int i = 1; i <= 6; i++) begin
        m_regs[i] = m_alt[i];
        m_alt[i]  = old_main[i];
      end
    end
    if (c.ex_af) begin
      a_old   = m_a;
      f_old   = m_f;
      m_a     = m_a_alt;
      m_f     = m_f_alt;
      m_a_alt = a_old;
      m_f_alt = f_old;
    end else begin
      if (c.ld_a) begin
        m_a = e_dbus;
      end
      f_new = (c.fsrc == F_ALU8) ? e_alu8_f : (c.fsrc == F_ALU16) ? e_alu16_f : m_f;
      f_new.s  = force_bit(f_new.s, c.fforce.s);
      f_new.z  = force_bit(f_new.z, c.fforce.z);
      f_new.h  = force_bit(f_new.h, c.fforce.h);
      f_new.pv = force_bit(f_new.pv, c.fforce.pv);
      f_new.n  = force_bit(f_new.n, c.fforce.n);
      f_new.c  = force_bit(f_new.c, c.fforce.c);
      if (c.fsrc != F_KEEP || c.fforce != '0) begin
        m_f = f_new;
      end
    end
    if (c.ld_temp) begin
      m_temp = e_dbus;
    end
    if (c.ld_mar_hi) begin
      m_mar[15:8] = e_abus[15:8];
    end
    if (c.ld_mar_lo) begin
      m_mar[7:0] = e_abus[7:0];
    end
  endtask

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  // ----------------------------------------------------------
  // one operation, called right after a rising edge
  // ----------------------------------------------------------
  task automatic step(input ctl_t c, input byte_t din);
    #1;
    ctl     = c;
    data_in = din;
    predict(c, din);
    // outputs settled mid cycle
    @(negedge clk);
    check("data_out", (c.dsrc != D_EXT) ? e_dbus : 8'h00, data_out);
    check("data_oe", c.dsrc != D_EXT, data_oe);
    check("addr_out", (c.asrc != A_NONE) ? e_abus : 16'h0000, addr_out);
    check("addr_oe", c.asrc != A_NONE, addr_oe);
    check("flags", m_f, flags);
    @(posedge clk);
    update_model(c);
  endtask

  function automatic reg8_e pick_reg8();
    return reg8_e'($urandom_range(14, 1));
  endfunction

  function automatic pair_e pick_pair();
    return pair_e'($urandom_range(7, 1));
  endfunction

  function automatic flag_force_t pick_forces();
    flag_force_t f;
    force_e      opts [3];
    opts = '{FORCE_KEEP, FORCE_CLR, FORCE_SET};
    f.s  = opts[$urandom_range(2)];
    f.z  = opts[$urandom_range(2)];
    f.h  = opts[$urandom_range(2)];
    f.pv = opts[$urandom_range(2)];
    f.n  = opts[$urandom_range(2)];
    f.c  = opts[$urandom_range(2)];
    return f;
  endfunction

  function automatic byte_t next_byte();
    return byte_t'($urandom());
  endfunction

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %s done: %0d errors", test_name, test_errors);
  endtask

  // ----------------------------------------------------------
  // tests
  // ----------------------------------------------------------
  task automatic byte_loads();
    ctl_t c;
    begin_test("byte_load");
    repeat (OPS) begin
      c = '0;
      if ($urandom_range(1) == 1) begin
        c.ld8 = pick_reg8();
      end else begin
        c.dsrc = D_REG;
        c.rd8  = pick_reg8();
      end
      step(c, next_byte());
    end
    end_test();
  endtask

  task automatic pair_and_mar();
    ctl_t c;
    begin_test("pair_mar");
    repeat (OPS) begin
      c      = '0;
      c.pair = pick_pair();
      case ($urandom_range(5))
        0: c.ld_temp = 1'b1;
        1: begin
          // pair from TEMP through the 16-bit alu
          c.asrc    = A_ALU;
          c.alu_op  = OP_PASS_B;
          c.ld_pair = 1'b1;
        end
        2: begin
          c.asrc      = A_PAIR;
          c.ld_mar_hi = 1'b1;
        end
        3: begin
          c.asrc      = A_PAIR;
          c.ld_mar_lo = 1'b1;
        end
        4: begin
          c.asrc    = A_MAR;
          c.ld_pair = 1'b1;
        end
        default: begin
          // TEMP on the data bus, MAR or pair on the address bus
          c.asrc = ($urandom_range(1) == 1) ? A_MAR : A_PAIR;
          c.dsrc = D_TEMP;
        end
      endcase
      step(c, next_byte());
    end
    end_test();
  endtask

  task automatic exchanges();
    ctl_t c;
    begin_test("exchange");
    repeat (OPS) begin
      c       = '0;
      c.exx   = ($urandom_range(3) == 0);
      c.ex_af = ($urandom_range(3) == 0);
      // D_EXT, D_REG, D_A or D_F
      c.dsrc  = dsrc_e'($urandom_range(3));
      c.rd8   = pick_reg8();
      c.asrc  = A_PAIR;
      c.pair  = pick_pair();
      case ($urandom_range(2))
        0:       c.ld8 = pick_reg8();
        1:       c.ld_a = 1'b1;
        default: c.fforce = pick_forces();
      endcase
      step(c, next_byte());
    end
    end_test();
  endtask

  task automatic alu8_ops();
    ctl_t c;
    begin_test("alu8");
    repeat (OPS) begin
      c      = '0;
      c.ld_a = 1'b1;
      if ($urandom_range(4) != 0) begin
        c.alu_op = alu_op_e'($urandom_range(5));
        c.dsrc   = D_ALU;
        c.fsrc   = F_ALU8;
      end
      step(c, next_byte());
    end
    end_test();
  endtask

  task automatic alu16_ops();
    ctl_t c;
    begin_test("alu16");
    repeat (OPS) begin
      c = '0;
      case ($urandom_range(3))
        0: c.ld_temp = 1'b1;
        1: c.ld8 = pick_reg8();
        default: begin
          // pair plus signed TEMP, sometimes written back
          c.pair    = pick_pair();
          c.asrc    = A_ALU;
          c.alu_op  = OP_ADD_SE;
          c.fsrc    = F_ALU16;
          c.ld_pair = $urandom_range(1);
        end
      endcase
      step(c, next_byte());
    end
    end_test();
  endtask

  task automatic flag_forcing();
    ctl_t c;
    begin_test("flag_force");
    repeat (OPS) begin
      c        = '0;
      c.fsrc   = fsrc_e'($urandom_range(2));
      c.alu_op = alu_op_e'($urandom_range(5));
      c.fforce = pick_forces();
      c.dsrc   = D_F;
      c.asrc   = A_PAIR;
      c.pair   = pick_pair();
      step(c, next_byte());
    end
    end_test();
  endtask

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hbf82));
    ctl     = '0;
    data_in = '0;
    checks  = 0;
    errors  = 0;
    cycles  = 0;
    // every register is zero out of reset
    for (int i = 1; i <= 14; i++) begin
      m_regs[i] = '0;
    end
    for (int i = 1; i <= 6; i++) begin
      m_alt[i] = '0;
    end
    m_a     = '0;
    m_a_alt = '0;
    m_f     = '0;
    m_f_alt = '0;
    m_temp  = '0;
    m_mar   = '0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    byte_loads();
    pair_and_mar();
    exchanges();
    alu8_ops();
    alu16_ops();
    flag_forcing();
    assert_fails = u_z80_datapath.u_z80_datapath_asserts.fail_count;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             TESTS, checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/z80_datapath_asserts.sv
`default_nettype none

module z80_datapath_asserts import datapath_pkg::*; (
  input logic clk,
  input logic rst_n,
  input ctl_t ctl,
  input logic data_oe,
  input logic addr_oe
);

  timeunit 1ns;
  timeprecision 100ps;

  // read by the testbench at the end of the run
  int fail_count = 0;

  // no bus driven out of reset
  oe_in_reset: assert property (@(posedge clk) !rst_n |-> (!data_oe && !addr_oe))
    else begin
      fail_count++;
      $error("output enable high during reset");
    end

  // data_oe follows the data bus source
  data_oe_src: assert property (@(posedge clk) data_oe == (ctl.dsrc != D_EXT))
    else begin
      fail_count++;
      $error("data_oe does not match dsrc");
    end

  // one register file write port per cycle
  one_load: assert property (@(posedge clk) !((ctl.ld8 != R8_NONE) && ctl.ld_pair))
    else begin
      fail_count++;
      $error("ld8 and ld_pair active together");
    end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // free running clock
  initial begin
    clk = 1'b0;
    forever #(period_ns / 2.0) clk = ~clk;
  end

  // reset low for a fixed number of cycles, released just after an edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: logic/z80_datapath.sv
`default_nettype none

module z80_datapath import datapath_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  ctl_t   ctl,
  input  byte_t  data_in,
  output byte_t  data_out,
  output logic   data_oe,
  output word_t  addr_out,
  output logic   addr_oe,
  output flags_t flags
);

  // ----------------------------------------------------------
  // internal buses and unit outputs
  // ----------------------------------------------------------
  byte_t      dbus;
  addr_word_u abus;
  byte_t      reg8_val;
  word_t      pair_val;
  byte_t      a_val;
  byte_t      temp_val;
  byte_t      alu8_res;
  word_t      alu16_res;
  flags_t     alu8_flags;
  flags_t     alu16_flags;

  register_file u_register_file (
    .clk, .rst_n,
    .rd8(ctl.rd8), .ld8(ctl.ld8), .pair(ctl.pair),
    .ld_pair(ctl.ld_pair), .exx(ctl.exx),
    .dbus, .abus, .reg8_val, .pair_val
  );

  // 8-bit alu works on A and the external data input
  alu #(.width(BYTE_W)) u_alu8 (
    .a(a_val), .b(data_in), .op(ctl.alu_op), .f_in(flags),
    .res(alu8_res), .f_out(alu8_flags)
  );

  // 16-bit alu works on a pair and TEMP, zero extended
  alu #(.width(WORD_W)) u_alu16 (
    .a(pair_val), .b(WORD_W'(temp_val)), .op(ctl.alu_op), .f_in(flags),
    .res(alu16_res), .f_out(alu16_flags)
  );

  // F goes straight out to the control unit
  accum_flags u_accum_flags (
    .clk, .rst_n, .ld_a(ctl.ld_a), .fsrc(ctl.fsrc), .fforce(ctl.fforce),
    .ex_af(ctl.ex_af), .dbus, .alu8_flags, .alu16_flags,
    .a_val, .f_val(flags)
  );

  bus_arbiter u_bus_arbiter (
    .clk, .rst_n, .dsrc(ctl.dsrc), .asrc(ctl.asrc),
    .ld_temp(ctl.ld_temp), .ld_mar_hi(ctl.ld_mar_hi), .ld_mar_lo(ctl.ld_mar_lo),
    .data_in, .reg8_val, .a_val, .f_val(flags), .alu8_res, .pair_val, .alu16_res,
    .dbus, .abus, .temp_val, .data_out, .data_oe, .addr_out, .addr_oe
  );

endmodule

`default_nettype wire

// File: logic/bus_arbiter.sv
`default_nettype none

module bus_arbiter import datapath_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  dsrc_e      dsrc,
  input  asrc_e      asrc,
  input  logic       ld_temp,
  input  logic       ld_mar_hi,
  input  logic       ld_mar_lo,
  input  byte_t      data_in,
  input  byte_t      reg8_val,
  input  byte_t      a_val,
  input  flags_t     f_val,
  input  byte_t      alu8_res,
  input  word_t      pair_val,
  input  word_t      alu16_res,
  output byte_t      dbus,
  output addr_word_u abus,
  output byte_t      temp_val,
  output byte_t      data_out,
  output logic       data_oe,
  output word_t      addr_out,
  output logic       addr_oe
);

  byte_t      temp_q;
  addr_word_u mar_q;

  // ----------------------------------------------------------
  // internal data bus
  // ----------------------------------------------------------
  always_comb begin
    case (dsrc)
      D_REG:   dbus = reg8_val;
      D_A:     dbus = a_val;
      D_F:     dbus = byte_t'(f_val);
      D_TEMP:  dbus = temp_q;
      D_ALU:   dbus = alu8_res;
      // undriven, external data shows through
      default: dbus = data_in;
    endcase
  end

  // ----------------------------------------------------------
  // internal address bus, zero when idle
  // ----------------------------------------------------------
  always_comb begin
    case (asrc)
      A_PAIR:  abus.word = pair_val;
      A_MAR:   abus.word = mar_q.word;
      A_ALU:   abus.word = alu16_res;
      default: abus.word = '0;
    endcase
  end

  // TEMP and MAR, MAR bytes load independently
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      temp_q     <= '0;
      mar_q.word <= '0;
    end else begin
      if (ld_temp) begin
        temp_q <= dbus;
      end
      if (ld_mar_hi) begin
        mar_q.bytes.hi <= abus.bytes.hi;
      end
      if (ld_mar_lo) begin
        mar_q.bytes.lo <= abus.bytes.lo;
      end
    end
  end

  assign temp_val = temp_q;

  // external side, zero instead of high-z when not enabled
  assign data_oe  = (dsrc != D_EXT);
  assign addr_oe  = (asrc != A_NONE);
  assign data_out = data_oe ? dbus : '0;
  assign addr_out = addr_oe ? abus.word : '0;

endmodule

`default_nettype wire

// File: logic/accum_flags.sv
`default_nettype none

module accum_flags import datapath_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        ld_a,
  input  fsrc_e       fsrc,
  input  flag_force_t fforce,
  input  logic        ex_af,
  input  byte_t       dbus,
  input  flags_t      alu8_flags,
  input  flags_t      alu16_flags,
  output byte_t       a_val,
  output flags_t      f_val
);

  byte_t  a_q;
  byte_t  a_alt_q;
  flags_t f_q;
  flags_t f_alt_q;
  // selected flag source before and after forcing
  flags_t f_src;
  flags_t f_next;
  logic   f_we;

  // one flag bit with its force applied
  function automatic logic apply_force(input logic cur, input force_e fc);
    logic v;
    v = cur;
    if (fc == FORCE_SET) begin
      v = 1'b1;
    end else if (fc == FORCE_CLR) begin
      v = 1'b0;
    end
    return v;
  endfunction

  // ----------------------------------------------------------
  // next flag value
  // ----------------------------------------------------------
  always_comb begin
    case (fsrc)
      F_ALU8:  f_src = alu8_flags;
      F_ALU16: f_src = alu16_flags;
      default: f_src = f_q;
    endcase
    // forces sit on top of whatever source was picked
    f_next    = f_src;
    f_next.s  = apply_force(f_src.s, fforce.s);
    f_next.z  = apply_force(f_src.z, fforce.z);
    f_next.h  = apply_force(f_src.h, fforce.h);
    f_next.pv = apply_force(f_src.pv, fforce.pv);
    f_next.n  = apply_force(f_src.n, fforce.n);
    f_next.c  = apply_force(f_src.c, fforce.c);
  end

  // write F on any alu source or any force
  assign f_we = (fsrc != F_KEEP) ||
                (fforce.s != FORCE_KEEP) || (fforce.z != FORCE_KEEP) ||
                (fforce.h != FORCE_KEEP) || (fforce.pv != FORCE_KEEP) ||
                (fforce.n != FORCE_KEEP) || (fforce.c != FORCE_KEEP);

  // ----------------------------------------------------------
  // registers, ex_af has priority over loads
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q     <= '0;
      a_alt_q <= '0;
      f_q     <= '0;
      f_alt_q <= '0;
    end else if (ex_af) begin
      a_q     <= a_alt_q;
      a_alt_q <= a_q;
      f_q     <= f_alt_q;
      f_alt_q <= f_q;
    end else begin
      if (ld_a) begin
        a_q <= dbus;
      end
      if (f_we) begin
        f_q <= f_next;
      end
    end
  end

  assign a_val = a_q;
  assign f_val = f_q;

endmodule

`default_nettype wire

// File: logic/alu.sv
`default_nettype none

module alu import datapath_pkg::*; #(
  parameter int width = 8
) (
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  input  alu_op_e          op,
  input  flags_t           f_in,
  output logic [width-1:0] res,
  output flags_t           f_out
);

  // one extra bit to catch the carry
  logic [width:0]   sum;
  logic [width-1:0] b_se;
  logic             arith;

  // low byte of b, sign extended to full width
  assign b_se = width'(signed'(b[BYTE_W-1:0]));

  // passes leave s and z alone
  assign arith = op inside {OP_INC, OP_DEC, OP_ADD, OP_ADD_SE};

  // ----------------------------------------------------------
  // result
  // ----------------------------------------------------------
  always_comb begin
    sum = '0;
    case (op)
      OP_INC:    res = a + 1'b1;
      OP_DEC:    res = a - 1'b1;
      OP_ADD: begin
        sum = {1'b0, a} + {1'b0, b};
        res = sum[width-1:0];
      end
      OP_ADD_SE: begin
        sum = {1'b0, a} + {1'b0, b_se};
        res = sum[width-1:0];
      end
      OP_PASS_B: res = b;
      // pass a, also covers unused codes
      default:   res = a;
    endcase
  end

  // ----------------------------------------------------------
  // flags, everything not touched comes through from f_in
  // ----------------------------------------------------------
  always_comb begin
    f_out = f_in;
    if (arith) begin
      f_out.z = (res == '0);
      f_out.s = res[width-1];
    end
    if (op == OP_ADD || op == OP_ADD_SE) begin
      f_out.c = sum[width];
    end
    // loop counter style test, pv means not yet zero
    if (op == OP_DEC) begin
      f_out.pv = (res != '0);
    end
  end

endmodule

`default_nettype wire

// File: logic/register_file.sv
`default_nettype none

module register_file import datapath_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  reg8_e      rd8,
  input  reg8_e      ld8,
  input  pair_e      pair,
  input  logic       ld_pair,
  input  logic       exx,
  input  byte_t      dbus,
  input  addr_word_u abus,
  output byte_t      reg8_val,
  output word_t      pair_val
);

  // ----------------------------------------------------------
  // storage
  // ----------------------------------------------------------
  // indexed straight by reg8_e code
  // 1..6 main B..L, 7..14 IXH..PCL
  byte_t regs_q [1:14];
  // alternate bank B'..L', same index as main
  byte_t alt_q [1:6];

  // byte slots of the selected pair
  logic [3:0] pair_hi;
  logic [3:0] pair_lo;
  logic       rd8_ok;
  logic       ld8_ok;

  // pair p lives at codes 2p-1 (hi) and 2p (lo)
  assign pair_lo = {pair, 1'b0};
  assign pair_hi = pair_lo - 4'd1;

  // guard against none and unused codes
  assign rd8_ok = rd8 inside {[R8_B:R8_PCL]};
  assign ld8_ok = ld8 inside {[R8_B:R8_PCL]};

  // ----------------------------------------------------------
  // read muxes, zero when nothing selected
  // ----------------------------------------------------------
  always_comb begin
    reg8_val = '0;
    if (rd8_ok) begin
      reg8_val = regs_q[rd8];
    end
  end

  always_comb begin
    pair_val = '0;
    if (pair != P_NONE) begin
      pair_val = {regs_q[pair_hi], regs_q[pair_lo]};
    end
  end

  // ----------------------------------------------------------
  // loads and bank exchange
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i <= 14; i++) begin
        regs_q[i] <= '0;
      end
      for (int i = 1; i <= 6; i++) begin
        alt_q[i] <= '0;
      end
    end else begin
      // byte load from the data bus
      if (ld8_ok) begin
        regs_q[ld8] <= dbus;
      end else if (ld_pair && pair != P_NONE) begin
        // word load, split by bytes off the address bus
        regs_q[pair_hi] <= abus.bytes.hi;
        regs_q[pair_lo] <= abus.bytes.lo;
      end
      // exx is assigned last so it overrides a load to B..L
      if (exx) begin
        for (int i = 1; i <= 6; i++) begin
          regs_q[i] <= alt_q[i];
          alt_q[i]  <= regs_q[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/datapath_pkg.sv
`default_nettype none

package datapath_pkg;

  // ----------------------------------------------------------
  // widths and basic types
  // ----------------------------------------------------------
  localparam int BYTE_W = 8;
  localparam int WORD_W = 16;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [WORD_W-1:0] word_t;

  // byte view of an address word
  typedef struct packed {
    byte_t hi;
    byte_t lo;
  } addr_bytes_t;

  // address bus word, used whole by the ALU and bus, by byte for pair/MAR loads
  typedef union packed {
    word_t       word;
    addr_bytes_t bytes;
  } addr_word_u;

  // ----------------------------------------------------------
  // selector encodings, value 0 is always idle
  // ----------------------------------------------------------
  // byte registers, pairs sit on odd/even codes (hi = 2p-1, lo = 2p)
  typedef enum logic [3:0] {
    R8_NONE, R8_B, R8_C, R8_D, R8_E, R8_H, R8_L,
    R8_IXH, R8_IXL, R8_IYH, R8_IYL, R8_SPH, R8_SPL, R8_PCH, R8_PCL
  } reg8_e;

  typedef enum logic [2:0] {P_NONE, P_BC, P_DE, P_HL, P_IX, P_IY, P_SP, P_PC} pair_e;

  // data bus source, D_EXT leaves the bus to data_in
  typedef enum logic [2:0] {D_EXT, D_REG, D_A, D_F, D_TEMP, D_ALU} dsrc_e;

  typedef enum logic [1:0] {A_NONE, A_PAIR, A_MAR, A_ALU} asrc_e;

  typedef enum logic [2:0] {
    OP_PASS_A, OP_INC, OP_DEC, OP_ADD, OP_PASS_B, OP_ADD_SE
  } alu_op_e;

  typedef enum logic [1:0] {F_KEEP, F_ALU8, F_ALU16} fsrc_e;

  // per-flag force, 2'b1x forces and bit 0 is the value
  typedef enum logic [1:0] {FORCE_KEEP = 2'b00, FORCE_CLR = 2'b10, FORCE_SET = 2'b11} force_e;

  // ----------------------------------------------------------
  // flag register and control word
  // ----------------------------------------------------------
  typedef struct packed {
    logic s;
    logic z;
    logic y;
    logic h;
    logic x;
    logic pv;
    logic n;
    logic c;
  } flags_t;

  // y and x are undocumented, never forced
  typedef struct packed {
    force_e s;
    force_e z;
    force_e h;
    force_e pv;
    force_e n;
    force_e c;
  } flag_force_t;

  typedef struct packed {
    dsrc_e       dsrc;
    asrc_e       asrc;
    reg8_e       rd8;
    reg8_e       ld8;
    pair_e       pair;
    logic        ld_pair;
    logic        ld_a;
    fsrc_e       fsrc;
    flag_force_t fforce;
    alu_op_e     alu_op;
    logic        ld_temp;
    logic        ld_mar_hi;
    logic        ld_mar_lo;
    logic        exx;
    logic        ex_af;
  } ctl_t;

endpackage

`default_nettype wire
